//--- core_mem_path.sv
`timescale 1ns/1ns
`default_nettype none

module core_mem_path (
    input  logic                          clk,
    input  logic                          a_rst,

    // Scheduler address generator
    input  logic                          i_agu_req,
    input  logic [core_pkg::ADDR_W-1:0]   i_agu_addr,
    input  logic [core_pkg::DATA_W-1:0]   i_agu_data,
    input  logic                          i_agu_width,
    input  logic                          i_agu_cmd,
    input  logic                          i_agu_tag,
    output logic                          o_agu_wait,

    // RMW control
    input  logic                          i_rmw_start,
    input  logic [core_pkg::ADDR_W-1:0]   i_rmw_addr,
    input  logic [core_pkg::RMW_FN_W-1:0] i_rmw_fn,
    input  logic                          i_rmw_flags_wr,
    input  logic [core_pkg::FLAG_W-1:0]   i_flags,
    output logic                          o_rmw_busy,
    output logic [core_pkg::FLAG_W-1:0]   o_flags,
    output logic                          o_flags_wr,

    // Data memory bus
    input  logic                          i_mem_rdy,
    input  logic [core_pkg::DATA_W-1:0]   i_mem_data,
    output logic [core_pkg::ADDR_W-1:0]   o_mem_addr,
    output logic [core_pkg::DATA_W-1:0]   o_mem_data,
    output logic                          o_mem_cmd,
    output logic                          o_mem_assert,
    output logic                          o_mem_be0,
    output logic                          o_mem_be1,

    // Load results to the scheduler
    output logic                          o_ld_wb,
    output logic                          o_ld_tag,
    output logic [core_pkg::DATA_W-1:0]   o_ld_data
);
    import core_pkg::*;

    logic [ADDR_W-1:0] rq_addr;
    logic [DATA_W-1:0] rq_data;
    logic              rq_width;
    logic              rq_cmd;
    logic [TAG_W-1:0]  rq_tag;
    logic              rq_start;
    logic              rq_hold;

    logic              rmw_taken;
    logic              rmw_req;
    logic [ADDR_W-1:0] rmw_lock_addr;
    logic [DATA_W-1:0] rmw_data;
    logic              rmw_cmd;
    logic [TAG_W-1:0]  rmw_tag;

    logic              rs_wb;
    logic [TAG_W-1:0]  rs_tag;
    logic [DATA_W-1:0] rs_data;

    rq_arbiter u_arb (
        .i_agu_req   (i_agu_req),
        .i_agu_addr  (i_agu_addr),
        .i_agu_data  (i_agu_data),
        .i_agu_width (i_agu_width),
        .i_agu_cmd   (i_agu_cmd),
        .i_agu_tag   (i_agu_tag),
        .i_rmw_req   (rmw_req),
        .i_rmw_addr  (rmw_lock_addr),
        .i_rmw_data  (rmw_data),
        .i_rmw_cmd   (rmw_cmd),
        .i_rmw_tag   (rmw_tag),
        .i_rmw_lock  (o_rmw_busy),
        .i_rq_hold   (rq_hold),
        .o_agu_wait  (o_agu_wait),
        .o_rmw_taken (rmw_taken),
        .o_rq_addr   (rq_addr),
        .o_rq_data   (rq_data),
        .o_rq_width  (rq_width),
        .o_rq_cmd    (rq_cmd),
        .o_rq_tag    (rq_tag),
        .o_rq_start  (rq_start)
    );

    rmw_unit u_rmw (
        .clk         (clk),
        .a_rst       (a_rst),
        .i_start     (i_rmw_start),
        .i_addr      (i_rmw_addr),
        .i_fn        (i_rmw_fn),
        .i_flags_wr  (i_rmw_flags_wr),
        .i_flags     (i_flags),
        .i_taken     (rmw_taken),
        .i_rs_wb     (rs_wb),
        .i_rs_tag    (rs_tag),
        .i_rs_data   (rs_data),
        .o_busy      (o_rmw_busy),
        .o_lock_addr (rmw_lock_addr),
        .o_req       (rmw_req),
        .o_req_data  (rmw_data),
        .o_req_cmd   (rmw_cmd),
        .o_req_tag   (rmw_tag),
        .o_flags     (o_flags),
        .o_flags_wr  (o_flags_wr)
    );

    lsu_16b u_lsu (
        .clk          (clk),
        .a_rst        (a_rst),
        .i_rq_addr    (rq_addr),
        .i_rq_data    (rq_data),
        .i_rq_width   (rq_width),
        .i_rq_cmd     (rq_cmd),
        .i_rq_tag     (rq_tag),
        .i_rq_start   (rq_start),
        .o_rq_hold    (rq_hold),
        .i_mem_rdy    (i_mem_rdy),
        .i_mem_data   (i_mem_data),
        .o_mem_addr   (o_mem_addr),
        .o_mem_data   (o_mem_data),
        .o_mem_cmd    (o_mem_cmd),
        .o_mem_assert (o_mem_assert),
        .o_mem_be0    (o_mem_be0),
        .o_mem_be1    (o_mem_be1),
        .o_rs_wb      (rs_wb),
        .o_rs_tag     (rs_tag),
        .o_rs_data    (rs_data)
    );

    // RMW loads stay internal
    assign o_ld_wb   = rs_wb && !rs_tag[1];
    assign o_ld_tag  = rs_tag[0];
    assign o_ld_data = rs_data;

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;
    localparam int TAG_W  = 2;

    // Result tags; scheduler tags carry a zero prefix
    localparam logic [TAG_W-1:0] TAG_RMW_LD = 2'b10;
    localparam logic [TAG_W-1:0] TAG_RMW_ST = 2'b11;

    // Bus command
    localparam logic CMD_RD = 1'b0;
    localparam logic CMD_WR = 1'b1;

    // Request width
    localparam logic WIDTH_WORD = 1'b0;
    localparam logic WIDTH_BYTE = 1'b1;

    // RMW functions
    localparam int RMW_FN_W = 2;

    localparam logic [RMW_FN_W-1:0] RMW_INC = 2'b00;
    localparam logic [RMW_FN_W-1:0] RMW_DEC = 2'b01;
    localparam logic [RMW_FN_W-1:0] RMW_ROL = 2'b10; // Rotate through carry
    localparam logic [RMW_FN_W-1:0] RMW_INV = 2'b11;

    // Status flag word
    localparam int FLAG_W = 4;

    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

endpackage

`default_nettype wire

//--- lsu_16b.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_16b (
    input  logic                        clk,
    input  logic                        a_rst,

    input  logic [core_pkg::ADDR_W-1:0] i_rq_addr,
    input  logic [core_pkg::DATA_W-1:0] i_rq_data,
    input  logic                        i_rq_width,
    input  logic                        i_rq_cmd,
    input  logic [core_pkg::TAG_W-1:0]  i_rq_tag,
    input  logic                        i_rq_start,
    output logic                        o_rq_hold,

    input  logic                        i_mem_rdy,
    input  logic [core_pkg::DATA_W-1:0] i_mem_data,
    output logic [core_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [core_pkg::DATA_W-1:0] o_mem_data,
    output logic                        o_mem_cmd,
    output logic                        o_mem_assert,
    output logic                        o_mem_be0,
    output logic                        o_mem_be1,

    output logic                        o_rs_wb,
    output logic [core_pkg::TAG_W-1:0]  o_rs_tag,
    output logic [core_pkg::DATA_W-1:0] o_rs_data
);
    import core_pkg::*;

    logic              accept;
    logic              rq_word;
    logic              bus_done;
    logic              width_q;    // Width of the access in flight
    logic              sel_q;      // High byte selected
    logic [7:0]        lane;
    logic [DATA_W-1:0] rd_data;

    assign accept   = i_rq_start && !o_rq_hold;
    assign rq_word  = (i_rq_width == WIDTH_WORD);
    assign bus_done = o_mem_assert && i_mem_rdy;

    // Byte reads come back zero-extended
    assign lane    = sel_q ? i_mem_data[15:8] : i_mem_data[7:0];
    assign rd_data = (width_q == WIDTH_BYTE) ? {{(DATA_W-8){1'b0}}, lane} : i_mem_data;

    always_ff @(posedge clk or negedge a_rst) begin
        if (!a_rst) begin
            o_rq_hold    <= 1'b0;
            o_mem_assert <= 1'b0;
            o_rs_wb      <= 1'b0;
        end else begin
            o_rs_wb <= 1'b0;
            if (accept) begin
                o_rq_hold    <= 1'b1;
                o_mem_assert <= 1'b1;
            end else if (bus_done) begin
                o_mem_assert <= 1'b0;  // Hold stays up one more cycle
                o_rs_wb      <= (o_mem_cmd == CMD_RD);
            end else if (!o_mem_assert) begin
                o_rq_hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_mem_addr <= {i_rq_addr[ADDR_W-1:1], 1'b0};
            o_mem_cmd  <= i_rq_cmd;
            o_mem_be0  <= rq_word || !i_rq_addr[0];
            o_mem_be1  <= rq_word || i_rq_addr[0];
            // Byte stores go out on both lanes
            o_mem_data <= rq_word ? i_rq_data : {2{i_rq_data[7:0]}};
            width_q    <= i_rq_width;
            sel_q      <= i_rq_addr[0];
            o_rs_tag   <= i_rq_tag;
        end
        if (bus_done) begin
            o_rs_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- rmw_unit.sv
`timescale 1ns/1ns
`default_nettype none

module rmw_unit (
    input  logic                          clk,
    input  logic                          a_rst,

    input  logic                          i_start,
    input  logic [core_pkg::ADDR_W-1:0]   i_addr,
    input  logic [core_pkg::RMW_FN_W-1:0] i_fn,
    input  logic                          i_flags_wr,
    input  logic [core_pkg::FLAG_W-1:0]   i_flags,

    input  logic                          i_taken,
    input  logic                          i_rs_wb,
    input  logic [core_pkg::TAG_W-1:0]    i_rs_tag,
    input  logic [core_pkg::DATA_W-1:0]   i_rs_data,

    output logic                          o_busy,
    output logic [core_pkg::ADDR_W-1:0]   o_lock_addr,
    output logic                          o_req,
    output logic [core_pkg::DATA_W-1:0]   o_req_data,
    output logic                          o_req_cmd,
    output logic [core_pkg::TAG_W-1:0]    o_req_tag,
    output logic [core_pkg::FLAG_W-1:0]   o_flags,
    output logic                          o_flags_wr
);
    import core_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LD_REQ,
        S_LD_WAIT,
        S_MODIFY,
        S_ST_REQ
    } rmw_state_t;

    rmw_state_t state;

    logic [RMW_FN_W-1:0] fn_q;
    logic                flags_wr_q;
    logic                carry_q;     // Incoming C, used by ROL and INV
    logic [DATA_W-1:0]   word_q;      // Loaded word, later the result

    logic                load_hit;
    logic [DATA_W:0]     sum;
    logic [DATA_W-1:0]   res;
    logic [FLAG_W-1:0]   res_flags;

    assign load_hit = (state == S_LD_WAIT) && i_rs_wb && (i_rs_tag == TAG_RMW_LD);

    // Modify stage
    always_comb begin
        sum       = '0;
        res       = word_q;
        res_flags = '0;
        case (fn_q)
            RMW_INC: begin
                sum               = {1'b0, word_q} + (DATA_W+1)'(1);
                res               = sum[DATA_W-1:0];
                res_flags[FLAG_C] = sum[DATA_W];
                res_flags[FLAG_V] = (word_q == {1'b0, {(DATA_W-1){1'b1}}});
            end
            RMW_DEC: begin
                sum               = {1'b0, word_q} - (DATA_W+1)'(1);
                res               = sum[DATA_W-1:0];
                res_flags[FLAG_C] = sum[DATA_W]; // Borrow
                res_flags[FLAG_V] = (word_q == {1'b1, {(DATA_W-1){1'b0}}});
            end
            RMW_ROL: begin
                res               = {word_q[DATA_W-2:0], carry_q};
                res_flags[FLAG_C] = word_q[DATA_W-1];
            end
            default: begin
                res               = ~word_q;
                res_flags[FLAG_C] = carry_q;
            end
        endcase
        res_flags[FLAG_Z] = (res == '0);
        res_flags[FLAG_N] = res[DATA_W-1];
    end

    always_ff @(posedge clk or negedge a_rst) begin
        if (!a_rst) begin
            state      <= S_IDLE;
            o_flags_wr <= 1'b0;
        end else begin
            o_flags_wr <= 1'b0;
            case (state)
                S_IDLE:    if (i_start) state <= S_LD_REQ;
                S_LD_REQ:  if (i_taken) state <= S_LD_WAIT;
                S_LD_WAIT: if (load_hit) state <= S_MODIFY;
                S_MODIFY:  state <= S_ST_REQ;
                S_ST_REQ: begin
                    if (i_taken) begin
                        state      <= S_IDLE;
                        o_flags_wr <= flags_wr_q;
                    end
                end
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_start) begin
            o_lock_addr <= i_addr;
            fn_q        <= i_fn;
            flags_wr_q  <= i_flags_wr;
            carry_q     <= i_flags[FLAG_C];
        end
        if (load_hit) begin
            word_q <= i_rs_data;
        end
        if (state == S_MODIFY) begin
            word_q  <= res;
            o_flags <= res_flags;
        end
    end

    assign o_busy     = (state != S_IDLE);  // Also the address lock
    assign o_req      = (state == S_LD_REQ) || (state == S_ST_REQ);
    assign o_req_cmd  = (state == S_ST_REQ) ? CMD_WR : CMD_RD;
    assign o_req_tag  = (state == S_ST_REQ) ? TAG_RMW_ST : TAG_RMW_LD;
    assign o_req_data = word_q;

endmodule

`default_nettype wire

//--- rq_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rq_arbiter (
    input  logic                        i_agu_req,
    input  logic [core_pkg::ADDR_W-1:0] i_agu_addr,
    input  logic [core_pkg::DATA_W-1:0] i_agu_data,
    input  logic                        i_agu_width,
    input  logic                        i_agu_cmd,
    input  logic                        i_agu_tag,

    input  logic                        i_rmw_req,
    input  logic [core_pkg::ADDR_W-1:0] i_rmw_addr,
    input  logic [core_pkg::DATA_W-1:0] i_rmw_data,
    input  logic                        i_rmw_cmd,
    input  logic [core_pkg::TAG_W-1:0]  i_rmw_tag,
    input  logic                        i_rmw_lock,
    input  logic                        i_rq_hold,

    output logic                        o_agu_wait,
    output logic                        o_rmw_taken,
    output logic [core_pkg::ADDR_W-1:0] o_rq_addr,
    output logic [core_pkg::DATA_W-1:0] o_rq_data,
    output logic                        o_rq_width,
    output logic                        o_rq_cmd,
    output logic [core_pkg::TAG_W-1:0]  o_rq_tag,
    output logic                        o_rq_start
);
    import core_pkg::*;

    logic addr_clash;
    logic rmw_go;
    logic agu_go;

    // Same word as the locked RMW, byte offset ignored
    assign addr_clash = i_rmw_lock && (i_agu_addr[ADDR_W-1:1] == i_rmw_addr[ADDR_W-1:1]);

    assign rmw_go = i_rmw_req && !i_rq_hold;               // RMW always wins
    assign agu_go = i_agu_req && !i_rq_hold && !i_rmw_req && !addr_clash;

    assign o_rmw_taken = rmw_go;
    assign o_agu_wait  = i_agu_req && !agu_go;
    assign o_rq_start  = rmw_go || agu_go;

    always_comb begin
        if (i_rmw_req) begin
            o_rq_addr  = i_rmw_addr;
            o_rq_data  = i_rmw_data;
            o_rq_width = WIDTH_WORD;     // RMW is always a full word
            o_rq_cmd   = i_rmw_cmd;
            o_rq_tag   = i_rmw_tag;
        end else begin
            o_rq_addr  = i_agu_addr;
            o_rq_data  = i_agu_data;
            o_rq_width = i_agu_width;
            o_rq_cmd   = i_agu_cmd;
            o_rq_tag   = {{(TAG_W-1){1'b0}}, i_agu_tag};
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -f vlog.f --top-module tb_core_mem_path \
    -o tb_core_mem_path > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_core_mem_path > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

//--- tb_core_mem_path.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core_mem_path;
    import core_pkg::*;

    localparam logic [31:0] SEED = 32'h7887_917e;
    localparam int          TMO  = 200;  // Cycles allowed per wait

    logic        clk;
    logic        a_rst;
    logic        i_agu_req, i_agu_width, i_agu_cmd, i_agu_tag;
    logic [15:0] i_agu_addr, i_agu_data;
    logic        i_rmw_start, i_rmw_flags_wr;
    logic [15:0] i_rmw_addr;
    logic [1:0]  i_rmw_fn;
    logic [3:0]  i_flags;
    logic        i_mem_rdy;
    logic [15:0] i_mem_data;
    logic        o_agu_wait, o_rmw_busy, o_flags_wr;
    logic [3:0]  o_flags;
    logic [15:0] o_mem_addr, o_mem_data, o_ld_data;
    logic        o_mem_cmd, o_mem_assert, o_mem_be0, o_mem_be1, o_ld_wb, o_ld_tag;

    logic [15:0] mem [0:255];     // Memory model storage
    logic [15:0] shadow [0:255];  // Expected contents, kept in issue order
    logic [16:0] ld_q [$];        // {tag, data} per outstanding read
    logic [3:0]  fl_q [$];
    logic [16:0] ld_exp;
    logic [31:0] rnd_stim, rnd_mem;
    logic        mem_busy;
    logic [1:0]  wait_cnt;
    int          n_checks = 0;
    int          err_mis = 0;
    int          err_other = 0;

    core_mem_path u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Returns {V, C, N, Z, result}
    function automatic logic [19:0] rmw_ref(input logic [15:0] w, input logic [1:0] fn,
                                            input logic cin);
        logic [16:0] s;
        logic [15:0] r;
        logic        c;
        logic        v;
        v = 1'b0;
        case (fn)
            RMW_INC: begin
                s = {1'b0, w} + 17'd1;
                r = s[15:0];
                c = s[16];
                v = (w == 16'h7fff);
            end
            RMW_DEC: begin
                s = {1'b0, w} - 17'd1;
                r = s[15:0];
                c = s[16];               // Borrow
                v = (w == 16'h8000);
            end
            RMW_ROL: begin
                r = {w[14:0], cin};
                c = w[15];
            end
            default: begin
                r = ~w;
                c = cin;
            end
        endcase
        return {v, c, r[15], (r == 16'h0000), r};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_mis++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic draw_rand(output logic [31:0] r);
        rnd_stim = lcg_next(rnd_stim);
        r        = rnd_stim;
    endtask

    // Wait-state memory, 256 words, byte enables on writes
    initial begin
        i_mem_rdy  = 1'b0;
        i_mem_data = '0;
        mem_busy   = 1'b0;
        wait_cnt   = '0;
        rnd_mem    = lcg_next(SEED);
        forever begin
            tick();
            i_mem_rdy = 1'b0;
            if (o_mem_assert !== 1'b1) begin
                mem_busy = 1'b0;
            end else begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    rnd_mem  = lcg_next(rnd_mem);
                    wait_cnt = rnd_mem[17:16];  // 0 to 3 wait states
                end
                if (wait_cnt != 2'd0) begin
                    wait_cnt = wait_cnt - 2'd1;
                end else begin
                    check("o_mem_addr[0]", 32'(o_mem_addr[0]), 32'd0);
                    i_mem_data = mem[o_mem_addr[8:1]];
                    if (o_mem_cmd == CMD_WR && o_mem_be0)
                        mem[o_mem_addr[8:1]][7:0] = o_mem_data[7:0];
                    if (o_mem_cmd == CMD_WR && o_mem_be1)
                        mem[o_mem_addr[8:1]][15:8] = o_mem_data[15:8];
                    i_mem_rdy = 1'b1;
                    mem_busy  = 1'b0;
                end
            end
        end
    end

    // Compares load results and flag updates as they come out
    initial begin
        forever begin
            @(negedge clk);
            if (a_rst === 1'b1 && o_ld_wb === 1'b1) begin
                if (ld_q.size() == 0) begin
                    err_other++;
                    $display("ERROR at %0t ns: load result with no read outstanding", $time);
                end else begin
                    ld_exp = ld_q.pop_front();
                    check("o_ld_tag", 32'(o_ld_tag), 32'(ld_exp[16]));
                    check("o_ld_data", 32'(o_ld_data), 32'(ld_exp[15:0]));
                end
            end
            if (a_rst === 1'b1 && o_flags_wr === 1'b1) begin
                if (fl_q.size() == 0) begin
                    err_other++;
                    $display("ERROR at %0t ns: flag write with no flag update expected", $time);
                end else begin
                    check("o_flags", 32'(o_flags), 32'(fl_q.pop_front()));
                end
            end
        end
    end

    task automatic sched_access(input logic cmd, input logic width, input logic [15:0] addr,
                                input logic [15:0] data, input logic tag);
        int          n;
        logic [15:0] w;
        n           = 0;
        i_agu_req   = 1'b1;
        i_agu_cmd   = cmd;
        i_agu_width = width;
        i_agu_addr  = addr;
        i_agu_data  = data;
        i_agu_tag   = tag;
        @(negedge clk);
        while (o_agu_wait && n < TMO) begin
            @(negedge clk);
            n++;
        end
        w = shadow[addr[8:1]];
        if (o_agu_wait) begin
            err_other++;
            $display("ERROR at %0t ns: scheduler request to %h never taken", $time, addr);
        end else if (cmd == CMD_WR) begin
            if (width == WIDTH_WORD) w = data;
            else if (addr[0]) w[15:8] = data[7:0];
            else w[7:0] = data[7:0];
            shadow[addr[8:1]] = w;
        end else begin
            if (width == WIDTH_BYTE) w = addr[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
            ld_q.push_back({tag, w});
        end
        tick();  // Taken on this edge
        i_agu_req = 1'b0;
    endtask

    task automatic rmw_issue(input logic [15:0] addr, input logic [1:0] fn, input logic fwr,
                             input logic [3:0] flags);
        int          n;
        logic [19:0] r;
        n = 0;
        while (o_rmw_busy && n < TMO) begin
            tick();
            n++;
        end
        if (o_rmw_busy) begin
            err_other++;
            $display("ERROR at %0t ns: RMW unit stayed busy", $time);
        end else begin
            i_rmw_start    = 1'b1;
            i_rmw_addr     = addr;
            i_rmw_fn       = fn;
            i_rmw_flags_wr = fwr;
            i_flags        = flags;
            r = rmw_ref(shadow[addr[8:1]], fn, flags[FLAG_C]);
            shadow[addr[8:1]] = r[15:0];
            if (fwr) fl_q.push_back(r[19:16]);
            tick();
            i_rmw_start = 1'b0;
        end
    endtask

    function automatic logic traffic_pending();
        return ld_q.size() != 0 || fl_q.size() != 0 || o_rmw_busy || o_mem_assert;
    endfunction

    task automatic drain_traffic();
        int n;
        n = 0;
        while (traffic_pending() && n < TMO) begin
            tick();
            n++;
        end
        if (traffic_pending()) begin
            err_other++;
            $display("ERROR at %0t ns: memory traffic did not drain", $time);
        end
        repeat (2) tick();
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 256; i++) begin
            check($sformatf("mem[%0d]", i), 32'(mem[i]), 32'(shadow[i]));
        end
    endtask

    initial begin : main
        logic [31:0] r1;
        logic [31:0] r2;
        logic [15:0] addr;
        logic [15:0] edge_v [0:5];
        edge_v         = '{16'h0000, 16'hFFFF, 16'h7FFF, 16'h8000, 16'h0001, 16'h5AC3};
        a_rst          = 1'b0;
        i_agu_req      = 1'b0;
        i_agu_width    = WIDTH_WORD;
        i_agu_cmd      = CMD_RD;
        i_agu_tag      = 1'b0;
        i_agu_addr     = '0;
        i_agu_data     = '0;
        i_rmw_start    = 1'b0;
        i_rmw_addr     = '0;
        i_rmw_fn       = RMW_INC;
        i_rmw_flags_wr = 1'b0;
        i_flags        = '0;
        rnd_stim       = SEED;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = {8'(i) ^ 8'h5A, ~8'(i)};
            shadow[i] = mem[i];
        end
        repeat (2) @(posedge clk);
        #2;
        a_rst = 1'b1;

        check("o_mem_assert", 32'(o_mem_assert), 32'd0);
        check("o_ld_wb", 32'(o_ld_wb), 32'd0);
        check("o_flags_wr", 32'(o_flags_wr), 32'd0);
        check("o_rmw_busy", 32'(o_rmw_busy), 32'd0);
        check("o_agu_wait", 32'(o_agu_wait), 32'd0);

        // Word writes, then reads in issue order
        for (int i = 0; i < 8; i++)
            sched_access(CMD_WR, WIDTH_WORD, 16'h0010 + 16'(2 * i),
                         16'hC35A ^ (16'(i) * 16'h1111), 1'b0);
        for (int i = 0; i < 8; i++)
            sched_access(CMD_RD, WIDTH_WORD, 16'h0010 + 16'(2 * i), 16'h0000, 1'(i));
        drain_traffic();

        // Byte lanes and their neighbours
        sched_access(CMD_WR, WIDTH_BYTE, 16'h0021, 16'h77A5, 1'b0);
        sched_access(CMD_WR, WIDTH_BYTE, 16'h0024, 16'h883C, 1'b1);
        sched_access(CMD_RD, WIDTH_BYTE, 16'h0021, 16'h0000, 1'b1);
        sched_access(CMD_RD, WIDTH_BYTE, 16'h0020, 16'h0000, 1'b0);
        sched_access(CMD_RD, WIDTH_WORD, 16'h0020, 16'h0000, 1'b1);
        sched_access(CMD_RD, WIDTH_BYTE, 16'h0024, 16'h0000, 1'b0);
        sched_access(CMD_RD, WIDTH_BYTE, 16'h0025, 16'h0000, 1'b1);
        sched_access(CMD_RD, WIDTH_WORD, 16'h0024, 16'h0000, 1'b0);
        drain_traffic();

        // Each RMW function over edge values, the last run without flag write
        for (int f = 0; f < 4; f++) begin
            for (int j = 0; j < 8; j++) begin
                draw_rand(r1);
                addr = 16'h0080 + 16'(2 * f);
                sched_access(CMD_WR, WIDTH_WORD, addr, (j < 6) ? edge_v[j] : r1[31:16], 1'b0);
                rmw_issue(addr, 2'(f), j != 7, (j % 2 == 1) ? 4'b0100 : 4'b1011);
                drain_traffic();
                check($sformatf("mem[%0d] after RMW", addr[8:1]), 32'(mem[addr[8:1]]),
                      32'(shadow[addr[8:1]]));
            end
        end

        // Reads that hit the locked word see the stored result
        sched_access(CMD_WR, WIDTH_WORD, 16'h00C0, 16'h00FF, 1'b0);
        rmw_issue(16'h00C1, RMW_INC, 1'b1, 4'b0000);
        sched_access(CMD_RD, WIDTH_WORD, 16'h00C0, 16'h0000, 1'b1);
        sched_access(CMD_RD, WIDTH_BYTE, 16'h00C1, 16'h0000, 1'b0);
        drain_traffic();

        // Random mix, half of it packed into a few words
        for (int k = 0; k < 400; k++) begin
            draw_rand(r1);
            draw_rand(r2);
            addr = r1[20] ? {7'd0, r1[31:23]} : {12'd0, r1[19:16]};
            case (r1[14:12])
                3'd0, 3'd1, 3'd2: sched_access(CMD_RD, r1[11], addr, 16'h0000, r1[10]);
                3'd3, 3'd4, 3'd5: sched_access(CMD_WR, r1[11], addr, r2[31:16], r1[10]);
                default:          rmw_issue(addr, r2[25:24], r2[23], r2[31:28]);
            endcase
        end
        drain_traffic();
        compare_memory();

        $display("Done: %0d checks, %0d mismatches, %0d other errors",
                 n_checks, err_mis, err_other);
        if (err_mis == 0 && err_other == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
core_pkg.sv
rq_arbiter.sv
rmw_unit.sv
lsu_16b.sv
core_mem_path.sv
tb_core_mem_path.sv
